// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // base opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    // instruction word, one view per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [4:0] rd;  opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
            logic [4:0]  rd;  opcode_e    opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3;   logic [4:0] imm_4_0; opcode_e opcode;
        } s_fmt;
        struct packed {
            logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; opcode_e opcode;
        } b_fmt;
        struct packed {
            logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
            logic [4:0] rd; opcode_e opcode;
        } j_fmt;
        struct packed {
            logic [19:0] imm_31_12; logic [4:0] rd; opcode_e opcode;
        } u_fmt;
    } instr_u;

    typedef struct packed {
        logic rf_we; wb_sel_e wb_sel; alu_op_e alu_op;
        logic a_is_zero; logic b_is_imm; logic is_branch; logic branch_ne;
        logic is_jal; logic is_load; logic mem_we;
    } ctrl_t;

    typedef struct packed {
        logic valid; logic [XLEN-1:0] pc; instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic valid; logic [XLEN-1:0] pc; ctrl_t ctrl;
        logic [REG_ADDR_W-1:0] rs1; logic [REG_ADDR_W-1:0] rs2; logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0] rd1; logic [XLEN-1:0] rd2; logic [XLEN-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic valid; logic [XLEN-1:0] pc; logic rf_we; wb_sel_e wb_sel;
        logic is_load; logic mem_we; logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0] alu_c; logic [XLEN-1:0] store_data;
    } ex_mem_t;

    // retiring instruction, also the register file write port
    typedef struct packed {
        logic valid; logic [XLEN-1:0] pc; logic we;
        logic [REG_ADDR_W-1:0] rd; logic [XLEN-1:0] data;
    } wb_trace_t;

endpackage

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] target_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  instr_u          imem_data_i,
    output if_id_t          if_id_o
);

    logic [XLEN-1:0] pc_q;
    if_id_t          if_id_q;

    assign imem_addr_o = pc_q;
    assign if_id_o     = if_id_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q          <= RESET_PC;
            if_id_q.valid <= 1'b0;
        end else if (redirect_i) begin
            // drop the slot fetched behind the taken jump
            pc_q          <= target_i;
            if_id_q.valid <= 1'b0;
        end else if (!stall_i) begin
            pc_q          <= pc_q + XLEN'(4);
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= imem_data_i;
        end
    end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import rv_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  if_id_t                if_id_i,
    input  logic                  stall_i,
    input  logic                  bubble_i,
    input  logic                  flush_i,
    input  wb_trace_t             wb_i,
    output id_ex_t                id_ex_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  uses_rs1_o,
    output logic                  uses_rs2_o
);

    instr_u          ins;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic            wr_en;
    logic [XLEN-1:0] regs [32];
    id_ex_t          id_ex_q;

    function automatic alu_op_e decode_alu(input logic [2:0] funct3, input logic alt,
                                           input logic is_reg);
        unique case (funct3)
            3'b000:  decode_alu = (alt && is_reg) ? SUB : ADD;
            3'b001:  decode_alu = SLL;
            3'b010:  decode_alu = SLT;
            3'b011:  decode_alu = SLTU;
            3'b100:  decode_alu = XOR;
            3'b101:  decode_alu = alt ? SRA : SRL;
            3'b110:  decode_alu = OR;
            default: decode_alu = AND;
        endcase
    endfunction

    assign ins   = if_id_i.instr;
    assign rs1_o = ins.r_fmt.rs1;
    assign rs2_o = ins.r_fmt.rs2;

    always_comb begin
        ctrl       = '0;
        imm        = '0;
        uses_rs1_o = 1'b0;
        uses_rs2_o = 1'b0;
        case (ins.r_fmt.opcode)
            OP: begin
                ctrl.rf_we  = 1'b1;
                ctrl.alu_op = decode_alu(ins.r_fmt.funct3, ins.r_fmt.funct7[5], 1'b1);
                uses_rs1_o  = 1'b1;
                uses_rs2_o  = 1'b1;
            end
            OP_IMM: begin
                // funct7 view still carries the shift type bit
                ctrl.rf_we    = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = decode_alu(ins.i_fmt.funct3, ins.r_fmt.funct7[5], 1'b0);
                imm           = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
                uses_rs1_o    = 1'b1;
            end
            LUI: begin
                ctrl.rf_we     = 1'b1;
                ctrl.a_is_zero = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                imm            = {ins.u_fmt.imm_31_12, 12'b0};
            end
            BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = ins.b_fmt.funct3[0];
                imm = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                       ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
                uses_rs1_o = 1'b1;
                uses_rs2_o = 1'b1;
            end
            JAL: begin
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.is_jal = 1'b1;
                imm = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                       ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
            end
            LOAD: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_MEM;
                ctrl.is_load  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                imm           = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
                uses_rs1_o    = 1'b1;
            end
            STORE: begin
                ctrl.mem_we   = 1'b1;
                ctrl.b_is_imm = 1'b1;
                imm = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
                uses_rs1_o = 1'b1;
                uses_rs2_o = 1'b1;
            end
            default: ;
        endcase
        // an empty slot never creates a hazard
        if (!if_id_i.valid) begin
            uses_rs1_o = 1'b0;
            uses_rs2_o = 1'b0;
        end
    end

    // register file, with the retiring write visible to this cycle's reads
    assign wr_en = wb_i.valid && wb_i.we && (wb_i.rd != '0);
    assign rd1 = (rs1_o == '0) ? '0 : (wr_en && wb_i.rd == rs1_o) ? wb_i.data : regs[rs1_o];
    assign rd2 = (rs2_o == '0) ? '0 : (wr_en && wb_i.rd == rs2_o) ? wb_i.data : regs[rs2_o];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_ex_q.valid <= 1'b0;
        end else begin
            id_ex_q.valid <= if_id_i.valid && !bubble_i && !flush_i;
            // payload holds while the fetch/decode register is stalled
            if (!stall_i) begin
                id_ex_q.pc   <= if_id_i.pc;
                id_ex_q.ctrl <= ctrl;
                id_ex_q.rs1  <= rs1_o;
                id_ex_q.rs2  <= rs2_o;
                id_ex_q.rd   <= ins.r_fmt.rd;
                id_ex_q.rd1  <= rd1;
                id_ex_q.rd2  <= rd2;
                id_ex_q.imm  <= imm;
            end
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  id_ex_t          id_ex_i,
    input  fwd_sel_e        fwd_a_i,
    input  fwd_sel_e        fwd_b_i,
    input  ex_mem_t         mem_i,
    input  wb_trace_t       wb_i,
    output logic            redirect_o,
    output logic [XLEN-1:0] target_o,
    output ex_mem_t         ex_mem_o
);

    logic [XLEN-1:0] a_fwd;
    logic [XLEN-1:0] b_fwd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_c;
    logic            taken;
    ex_mem_t         ex_mem_q;

    assign a_fwd = (fwd_a_i == FWD_MEM) ? mem_i.alu_c :
                   (fwd_a_i == FWD_WB)  ? wb_i.data : id_ex_i.rd1;
    assign b_fwd = (fwd_b_i == FWD_MEM) ? mem_i.alu_c :
                   (fwd_b_i == FWD_WB)  ? wb_i.data : id_ex_i.rd2;

    assign op_a = id_ex_i.ctrl.a_is_zero ? '0 : a_fwd;
    assign op_b = id_ex_i.ctrl.b_is_imm ? id_ex_i.imm : b_fwd;

    always_comb begin
        unique case (id_ex_i.ctrl.alu_op)
            SUB:     alu_c = op_a - op_b;
            AND:     alu_c = op_a & op_b;
            OR:      alu_c = op_a | op_b;
            XOR:     alu_c = op_a ^ op_b;
            SLL:     alu_c = op_a << op_b[4:0];
            SRL:     alu_c = op_a >> op_b[4:0];
            SRA:     alu_c = $unsigned($signed(op_a) >>> op_b[4:0]);
            SLT:     alu_c = XLEN'($signed(op_a) < $signed(op_b));
            SLTU:    alu_c = XLEN'(op_a < op_b);
            default: alu_c = op_a + op_b;
        endcase
    end

    // beq or bne, on the forwarded operands
    assign taken      = id_ex_i.ctrl.is_branch && ((a_fwd == b_fwd) != id_ex_i.ctrl.branch_ne);
    assign redirect_o = id_ex_i.valid && (taken || id_ex_i.ctrl.is_jal);
    assign target_o   = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_q.valid  <= 1'b0;
            ex_mem_q.mem_we <= 1'b0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.mem_we     <= id_ex_i.valid && id_ex_i.ctrl.mem_we;
            ex_mem_q.pc         <= id_ex_i.pc;
            ex_mem_q.rf_we      <= id_ex_i.ctrl.rf_we;
            ex_mem_q.wb_sel     <= id_ex_i.ctrl.wb_sel;
            ex_mem_q.is_load    <= id_ex_i.ctrl.is_load;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.alu_c      <= alu_c;
            ex_mem_q.store_data <= b_fwd;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

// ==== source/hazard_ctrl.sv ====
`timescale 1ns/1ns

module hazard_ctrl import rv_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  uses_rs1_i,
    input  logic                  uses_rs2_i,
    input  id_ex_t                id_ex_i,
    input  ex_mem_t               mem_i,
    input  wb_trace_t             wb_i,
    input  logic                  redirect_i,
    output logic                  stall_o,
    output logic                  bubble_o,
    output logic                  flush_o,
    output fwd_sel_e              fwd_a_o,
    output fwd_sel_e              fwd_b_o
);

    logic load_use;

    // younger producer wins; a load in memory never gets here thanks to the stall
    function automatic fwd_sel_e pick_fwd(input logic [REG_ADDR_W-1:0] src,
                                          input ex_mem_t mem, input wb_trace_t wb);
        if (mem.valid && mem.rf_we && !mem.is_load && mem.rd != '0 && mem.rd == src)
            return FWD_MEM;
        if (wb.valid && wb.we && wb.rd != '0 && wb.rd == src)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    assign load_use = id_ex_i.valid && id_ex_i.ctrl.is_load && (id_ex_i.rd != '0) &&
                      ((uses_rs1_i && rs1_i == id_ex_i.rd) || (uses_rs2_i && rs2_i == id_ex_i.rd));

    assign stall_o  = load_use;
    assign bubble_o = load_use;
    assign flush_o  = redirect_i;
    assign fwd_a_o  = pick_fwd(id_ex_i.rs1, mem_i, wb_i);
    assign fwd_b_o  = pick_fwd(id_ex_i.rs2, mem_i, wb_i);

endmodule

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ns

module writeback_stage import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  ex_mem_t         ex_mem_i,
    input  logic [XLEN-1:0] dmem_rdata_i,
    output wb_trace_t       trace_o
);

    logic [XLEN-1:0] wb_val;
    wb_trace_t       trace_q;

    always_comb begin
        unique case (ex_mem_i.wb_sel)
            WB_MEM:  wb_val = dmem_rdata_i;
            WB_PC4:  wb_val = ex_mem_i.pc + XLEN'(4);
            default: wb_val = ex_mem_i.alu_c;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            trace_q.valid <= 1'b0;
        end else begin
            trace_q.valid <= ex_mem_i.valid;
            trace_q.pc    <= ex_mem_i.pc;
            trace_q.we    <= ex_mem_i.rf_we;
            trace_q.rd    <= ex_mem_i.rd;
            // x0 always retires as zero
            trace_q.data  <= (ex_mem_i.rd == '0) ? '0 : wb_val;
        end
    end

    assign trace_o = trace_q;

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    // instruction memory
    output logic [XLEN-1:0] imem_addr_o,
    input  instr_u          imem_data_i,
    // data memory
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            dmem_we_o,
    input  logic [XLEN-1:0] dmem_rdata_i,
    // retirement trace
    output wb_trace_t       trace_o
);

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    wb_trace_t             wb;
    logic                  redirect;
    logic [XLEN-1:0]       target;
    logic                  stall;
    logic                  bubble;
    logic                  flush;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  uses_rs1;
    logic                  uses_rs2;

    // data memory is driven from the ex/mem register
    assign dmem_addr_o  = ex_mem.alu_c;
    assign dmem_wdata_o = ex_mem.store_data;
    assign dmem_we_o    = ex_mem.mem_we;
    assign trace_o      = wb;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall), .redirect_i(redirect),
        .target_i(target), .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .if_id_o(if_id)
    );

    decode_stage decode_i (
        .clk_i(clk_i), .rst_i(rst_i), .if_id_i(if_id), .stall_i(stall),
        .bubble_i(bubble), .flush_i(flush), .wb_i(wb), .id_ex_o(id_ex),
        .rs1_o(rs1), .rs2_o(rs2), .uses_rs1_o(uses_rs1), .uses_rs2_o(uses_rs2)
    );

    execute_stage execute_i (
        .clk_i(clk_i), .rst_i(rst_i), .id_ex_i(id_ex), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_i(ex_mem), .wb_i(wb), .redirect_o(redirect), .target_o(target),
        .ex_mem_o(ex_mem)
    );

    writeback_stage writeback_i (
        .clk_i(clk_i), .rst_i(rst_i), .ex_mem_i(ex_mem), .dmem_rdata_i(dmem_rdata_i),
        .trace_o(wb)
    );

    hazard_ctrl hazard_i (
        .rs1_i(rs1), .rs2_i(rs2), .uses_rs1_i(uses_rs1), .uses_rs2_i(uses_rs2),
        .id_ex_i(id_ex), .mem_i(ex_mem), .wb_i(wb), .redirect_i(redirect),
        .stall_o(stall), .bubble_o(bubble), .flush_o(flush), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

endmodule

// ==== bench/rv_core_asserts.sv ====
`timescale 1ns/1ns

module rv_core_asserts import rv_pkg::*; (
    input logic            clk_i,
    input logic            rst_i,
    input logic            dmem_we_i,
    input wb_trace_t       trace_i,
    input logic            redirect_i,
    input logic [XLEN-1:0] target_i,
    input logic [XLEN-1:0] pc_i
);

    // no stores while the core sits in reset
    no_store_in_reset: assert property (@(posedge clk_i) rst_i && $past(rst_i) |-> !dmem_we_i)
        else $error("data memory write during reset");

    first_cycle_idle: assert property (@(posedge clk_i) $fell(rst_i) |-> !trace_i.valid)
        else $error("trace valid right after reset");

    // a taken jump always lands on its target
    redirect_loads_pc: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_i |=> pc_i == $past(target_i))
        else $error("pc did not follow redirect");

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        trace_i.valid && trace_i.we && trace_i.rd == '0 |-> trace_i.data == '0)
        else $error("nonzero write data for x0");

endmodule

bind rv_core rv_core_asserts asserts_i (
    .clk_i(clk_i), .rst_i(rst_i), .dmem_we_i(dmem_we_o), .trace_i(trace_o),
    .redirect_i(redirect), .target_i(target), .pc_i(imem_addr_o)
);

// ==== bench/wb_checker.sv ====
`timescale 1ns/1ns

module wb_checker import rv_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  wb_trace_t   trace_i,
    input  logic        dmem_we_i,
    input  logic [31:0] dmem_addr_i,
    input  logic [31:0] dmem_wdata_i,
    input  int          test_id_i,
    output logic        done_o,
    output int          checks_o,
    output int          errors_o
);

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] next_pc;
        logic        st;
        logic [31:0] st_addr;
        logic [31:0] st_data;
    } ref_t;

    logic [31:0] ref_imem [256];
    logic [31:0] ref_mem [64];
    logic [31:0] ref_regs [32] = '{default: '0};
    logic [31:0] exp_pc;
    int          retired;
    int          test_errs;
    ref_t        exp;
    // address and data of each write seen on the data port
    logic [63:0] stores [$];
    logic [63:0] seen;

    initial begin
        checks_o = 0;
        errors_o = 0;
    end

    task automatic load_instr(input int idx, input logic [31:0] w);
        ref_imem[idx] = w;
    endtask

    task automatic load_data(input int idx, input logic [31:0] w);
        ref_mem[idx] = w;
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction of the ISA, updating the model state
    function automatic ref_t reference(input logic [31:0] pc);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] addr;
        ref_t        r;
        ins  = ref_imem[pc[9:2]];
        a    = ref_regs[ins[19:15]];
        b    = ref_regs[ins[24:20]];
        immi = {{20{ins[31]}}, ins[31:20]};
        r    = '{we: 1'b0, rd: ins[11:7], data: '0, next_pc: pc + 32'd4,
                 st: 1'b0, st_addr: '0, st_data: '0};
        case (ins[6:0])
            7'b0110011: begin
                r.we   = 1'b1;
                r.data = alu(ins[14:12], ins[30], a, b);
            end
            7'b0010011: begin
                r.we   = 1'b1;
                r.data = alu(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, immi);
            end
            7'b0110111: begin
                r.we   = 1'b1;
                r.data = {ins[31:12], 12'b0};
            end
            7'b1100011: begin
                if ((a == b) != ins[12])
                    r.next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'b1101111: begin
                r.we      = 1'b1;
                r.data    = pc + 32'd4;
                r.next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b0000011: begin
                addr   = a + immi;
                r.we   = 1'b1;
                r.data = ref_mem[addr[7:2]];
            end
            7'b0100011: begin
                addr      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                r.st      = 1'b1;
                r.st_addr = addr;
                r.st_data = b;
                ref_mem[addr[7:2]] = b;
            end
            default: ;
        endcase
        if (r.rd == 5'd0)
            r.data = '0;
        if (r.we && r.rd != 5'd0)
            ref_regs[r.rd] = r.data;
        return r;
    endfunction

    task automatic report(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors_o++;
        test_errs++;
    endtask

    // trace is stable on the falling edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            exp_pc    = '0;
            retired   = 0;
            test_errs = 0;
            stores.delete();
            done_o   <= 1'b0;
        end else begin
            // a store writes one cycle before it retires
            if (dmem_we_i)
                stores.push_back({dmem_addr_i, dmem_wdata_i});
            if (trace_i.valid && !done_o) begin
                exp = reference(exp_pc);
                checks_o++;
                retired++;
                if (trace_i.pc !== exp_pc)
                    report($sformatf("pc %h, expected %h", trace_i.pc, exp_pc));
                else if (trace_i.we !== exp.we)
                    report($sformatf("pc %h write enable %b, expected %b", exp_pc, trace_i.we, exp.we));
                else if (exp.we && (trace_i.rd !== exp.rd || trace_i.data !== exp.data))
                    report($sformatf("pc %h wrote x%0d=%h, expected x%0d=%h", exp_pc,
                                     trace_i.rd, trace_i.data, exp.rd, exp.data));
                if (exp.st) begin
                    if (stores.size() == 0) begin
                        report($sformatf("pc %h store missing on the data port", exp_pc));
                    end else begin
                        seen = stores.pop_front();
                        if (seen !== {exp.st_addr, exp.st_data})
                            report($sformatf("pc %h stored %h at %h, expected %h at %h",
                                             exp_pc, seen[31:0], seen[63:32],
                                             exp.st_data, exp.st_addr));
                    end
                end
                // jal to itself ends the program
                if (ref_imem[exp_pc[9:2]] == 32'h0000_006f) begin
                    if (stores.size() != 0)
                        report($sformatf("%0d data port writes with no store retiring",
                                         stores.size()));
                    done_o <= 1'b1;
                    $display("test %0d done: %0d retired, %0d errors", test_id_i, retired,
                             test_errs);
                end
                exp_pc = exp.next_pc;
            end
        end
    end

endmodule

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core import rv_pkg::*; ();

    localparam logic [31:0] NOP  = 32'h0000_0013;
    localparam logic [31:0] HALT = 32'h0000_006f;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imem_addr;
    instr_u      imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    wb_trace_t   trace;
    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    int          seed = 32'h96e5_89dd;
    int          prog_len = 0;
    int          test_id = 0;
    int          cycles = 0;
    int          limit = 1000;
    logic        done;
    int          checks;
    int          errors;

    rv_core #(.RESET_PC('0)) rv_core_i (
        .clk_i(clk), .rst_i(rst), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
        .dmem_rdata_i(dmem_rdata), .trace_o(trace)
    );

    wb_checker checker_i (
        .clk_i(clk), .rst_i(rst), .trace_i(trace), .dmem_we_i(dmem_we),
        .dmem_addr_i(dmem_addr), .dmem_wdata_i(dmem_wdata), .test_id_i(test_id),
        .done_o(done), .checks_o(checks), .errors_o(errors)
    );

    always #20 clk = ~clk;

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    // watchdog, limit is set per test from its length
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("simulation hung: test %0d did not reach its halt", test_id);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return enc_i(imm, rs1, 3'd0, rd, 7'b0010011);
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return enc_i(imm, rs1, 3'b010, rd, 7'b0000011);
    endfunction

    // any register, immediate or lui op with random function and immediate
    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        int         k;
        logic [4:0] shamt;
        k     = rnd(20);
        shamt = 5'(rnd(32));
        if (k < 8)
            return enc_r(7'h00, rs2, rs1, 3'(k), rd);
        if (k == 8)
            return enc_r(7'h20, rs2, rs1, 3'd0, rd);
        if (k == 9)
            return enc_r(7'h20, rs2, rs1, 3'd5, rd);
        if (k == 11 || k == 15)
            return enc_i({7'h00, shamt}, rs1, 3'(k - 10), rd, 7'b0010011);
        if (k < 18)
            return enc_i(12'(rnd(4096)), rs1, 3'(k - 10), rd, 7'b0010011);
        if (k == 18)
            return enc_i({7'h20, shamt}, rs1, 3'd5, rd, 7'b0010011);
        return {20'(rnd(1 << 20)), rd, 7'b0110111};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        checker_i.load_instr(prog_len, w);
        prog_len++;
    endtask

    // hold the core in reset while the next program is written
    task automatic begin_test(input int id);
        @(negedge clk);
        rst     = 1'b1;
        test_id = id;
        for (int k = 0; k < 256; k++) begin
            imem[k] = NOP;
            checker_i.load_instr(k, NOP);
        end
        prog_len = 0;
    endtask

    task automatic run_test();
        emit(HALT);
        limit = cycles + prog_len * 4 + 40;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        while (!done)
            @(negedge clk);
    endtask

    initial begin
        logic [31:0] fill;
        for (int k = 0; k < 64; k++) begin
            fill    = k * 32'h9e37_79b1 + 32'h3c6e_f372;
            dmem[k] = fill;
            checker_i.load_data(k, fill);
        end

        // independent ALU ops, registers seeded by lui and addi first
        begin_test(1);
        for (int r = 1; r < 16; r++) begin
            emit({20'(rnd(1 << 20)), 5'(r), 7'b0110111});
            emit(addi(5'(r), 5'(r), 12'(rnd(4096))));
        end
        for (int n = 0; n < 24; n++)
            emit(rand_alu(5'(16 + n % 8), 5'(1 + rnd(15)), 5'(1 + rnd(15))));
        run_test();

        // dependency chains at distance 1, 2 and 3
        begin_test(2);
        for (int n = 4; n < 28; n++)
            emit(rand_alu(5'(1 + n % 4), 5'(1 + (n - 1 - n % 3) % 4), 5'(1 + (n - 1) % 4)));
        run_test();

        // store then load, and loads used right away
        begin_test(3);
        emit(addi(5'd5, 5'd0, 12'd64));
        for (int n = 0; n < 4; n++) begin
            emit(addi(5'd6, 5'd6, 12'(rnd(4096))));
            emit(enc_s(12'(4 * n), 5'd6, 5'd5));
            emit(lw(5'd7, 5'd5, 12'(4 * n)));
            emit(enc_r(7'h00, 5'd6, 5'd7, 3'd0, 5'd8));
            emit(lw(5'd9, 5'd5, 12'(4 * n)));
            emit(enc_s(12'(4 * n + 32), 5'd9, 5'd5));
            emit(lw(5'd10, 5'd5, 12'(4 * n + 32)));
            emit(addi(5'd11, 5'd10, 12'd1));
        end
        run_test();

        // beq, bne and jal, taken and not taken
        begin_test(4);
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd5));
        emit(addi(5'd3, 5'd0, 12'd7));
        emit(enc_b(13'd12, 5'd2, 5'd1, 3'd0));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd5, 5'd0, 12'd3));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'd1));
        emit(addi(5'd6, 5'd0, 12'd4));
        emit(enc_b(13'd12, 5'd3, 5'd1, 3'd1));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd6, 5'd6, 12'd1));
        emit(enc_b(13'd8, 5'd3, 5'd1, 3'd0));
        emit(addi(5'd6, 5'd6, 12'd2));
        emit(enc_j(21'd12, 5'd1));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(enc_r(7'h00, 5'd0, 5'd1, 3'd0, 5'd7));
        emit(enc_j(21'd12, 5'd8));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(enc_r(7'h00, 5'd8, 5'd8, 3'd0, 5'd9));
        emit(addi(5'd10, 5'd0, 12'd9));
        emit(enc_b(13'd12, 5'd10, 5'd10, 3'd0));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(addi(5'd4, 5'd4, 12'd99));
        emit(enc_r(7'h20, 5'd9, 5'd10, 3'd0, 5'd11));
        run_test();

        // random mix, branches and jumps only go forward
        begin_test(5);
        for (int n = 0; n < 48; n++) begin
            case (rnd(10))
                6:       emit(lw(5'(1 + rnd(7)), 5'd0, 12'(4 * rnd(64))));
                7:       emit(enc_s(12'(4 * rnd(64)), 5'(1 + rnd(7)), 5'd0));
                8:       emit(enc_b(13'(4 * (2 + rnd(3))), 5'(1 + rnd(7)), 5'(1 + rnd(7)),
                                    3'(rnd(2))));
                9:       emit(enc_j(21'(4 * (2 + rnd(3))), 5'(rnd(8))));
                default: emit(rand_alu(5'(1 + rnd(7)), 5'(1 + rnd(7)), 5'(1 + rnd(7))));
            endcase
        end
        repeat (4) emit(NOP);
        run_test();

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
source/rv_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/hazard_ctrl.sv
source/writeback_stage.sv
source/rv_core.sv
bench/rv_core_asserts.sv
bench/wb_checker.sv
bench/tb_rv_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rv_core
FILELIST = sources.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
